/* rtl/cgra_config.svh */
// Mesh size, datapath widths and PE frame field positions
// Frame layout: opcode, two operand sources, output mask, immediate

`ifndef CGRA_CONFIG_SVH
`define CGRA_CONFIG_SVH

// Mesh dimensions
`define CGRA_ROWS 4
`define CGRA_COLS 4

// Datapath and frame widths
`define CGRA_DATA_WIDTH 16
`define CGRA_FRAME_WIDTH 64

// Frame field positions, bits 15:14 and 63:32 reserved
`define CGRA_OP_LSB 0
`define CGRA_SRC_A_LSB 4
`define CGRA_SRC_B_LSB 7
// Mask bit 0 north, 1 east, 2 south, 3 west
`define CGRA_MASK_LSB 10
`define CGRA_IMM_LSB 16

`endif

/* rtl/cgra_pkg.sv */
// Shared CGRA types
// ALU opcode enum and operand source enum

`default_nettype none

package cgra_pkg;

    // ==================================================
    // ALU opcodes
    // ==================================================
    // Codes 10 to 15 are treated as NOP by the decoder
    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_MUL  = 4'd3,
        OP_AND  = 4'd4,
        OP_OR   = 4'd5,
        OP_XOR  = 4'd6,
        OP_SHL  = 4'd7,
        OP_SHR  = 4'd8,
        OP_PASS = 4'd9
    } pe_opcode_e;

    // ==================================================
    // Operand sources
    // ==================================================
    // Codes 6 and 7 fall back to the immediate
    typedef enum logic [2:0] {
        SRC_N    = 3'd0,
        SRC_E    = 3'd1,
        SRC_S    = 3'd2,
        SRC_W    = 3'd3,
        SRC_SELF = 3'd4,
        SRC_IMM  = 3'd5
    } pe_src_e;

endpackage

`default_nettype wire

/* rtl/pe_config_decode.sv */
// PE frame register and field decode
// Operand selection and firing decision

`default_nettype none
`timescale 1ns/1ns

`include "cgra_config.svh"

module pe_config_decode import cgra_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [`CGRA_FRAME_WIDTH-1:0]  config_frame,
    input  logic                          config_valid,
    input  logic [`CGRA_DATA_WIDTH-1:0]   data_in_n,
    input  logic [`CGRA_DATA_WIDTH-1:0]   data_in_e,
    input  logic [`CGRA_DATA_WIDTH-1:0]   data_in_s,
    input  logic [`CGRA_DATA_WIDTH-1:0]   data_in_w,
    input  logic                          valid_in_n,
    input  logic                          valid_in_e,
    input  logic                          valid_in_s,
    input  logic                          valid_in_w,
    input  logic [`CGRA_DATA_WIDTH-1:0]   self_value,
    output pe_opcode_e                    opcode,
    output logic [`CGRA_DATA_WIDTH-1:0]   operand_a,
    output logic [`CGRA_DATA_WIDTH-1:0]   operand_b,
    output logic [3:0]                    out_mask,
    output logic                          fire
);

    logic [`CGRA_FRAME_WIDTH-1:0] frame_q;
    logic [3:0]                   op_raw;
    pe_src_e                      src_a;
    pe_src_e                      src_b;
    logic [`CGRA_DATA_WIDTH-1:0]  imm;
    logic                         a_valid;
    logic                         b_valid;

    function automatic logic [`CGRA_DATA_WIDTH-1:0] pick_operand(input pe_src_e src);
        case (src)
            SRC_N:    pick_operand = data_in_n;
            SRC_E:    pick_operand = data_in_e;
            SRC_S:    pick_operand = data_in_s;
            SRC_W:    pick_operand = data_in_w;
            SRC_SELF: pick_operand = self_value;
            default:  pick_operand = imm;
        endcase
    endfunction

    // Self and immediate sources are always ready
    function automatic logic source_valid(input pe_src_e src);
        case (src)
            SRC_N:   source_valid = valid_in_n;
            SRC_E:   source_valid = valid_in_e;
            SRC_S:   source_valid = valid_in_s;
            SRC_W:   source_valid = valid_in_w;
            default: source_valid = 1'b1;
        endcase
    endfunction

    // New frame takes effect the cycle after the strobe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            frame_q <= '0;
        end else if (config_valid) begin
            frame_q <= config_frame;
        end
    end

    assign op_raw   = frame_q[`CGRA_OP_LSB +: 4];
    assign opcode   = (op_raw > OP_PASS) ? OP_NOP : pe_opcode_e'(op_raw);
    assign src_a    = pe_src_e'(frame_q[`CGRA_SRC_A_LSB +: 3]);
    assign src_b    = pe_src_e'(frame_q[`CGRA_SRC_B_LSB +: 3]);
    assign out_mask = frame_q[`CGRA_MASK_LSB +: 4];
    assign imm      = frame_q[`CGRA_IMM_LSB +: `CGRA_DATA_WIDTH];

    always_comb begin
        operand_a = pick_operand(src_a);
        operand_b = pick_operand(src_b);
        a_valid   = source_valid(src_a);
        b_valid   = source_valid(src_b);
    end

    // No firing while frames are being loaded
    assign fire = !config_valid && (opcode != OP_NOP) && a_valid && b_valid;

endmodule

`default_nettype wire

/* rtl/pe_alu.sv */
// PE execute unit
// Combinational ALU over the ten opcodes, 16-bit wrapped results

`default_nettype none
`timescale 1ns/1ns

`include "cgra_config.svh"

module pe_alu import cgra_pkg::*; (
    input  pe_opcode_e                   opcode,
    input  logic [`CGRA_DATA_WIDTH-1:0]  operand_a,
    input  logic [`CGRA_DATA_WIDTH-1:0]  operand_b,
    output logic [`CGRA_DATA_WIDTH-1:0]  result
);

    logic [3:0] shamt;

    // Shift amount from the low bits of B only
    assign shamt = operand_b[3:0];

    always_comb begin
        result = '0;
        case (opcode)
            OP_ADD:  result = operand_a + operand_b;
            OP_SUB:  result = operand_a - operand_b;
            // Low half of the product
            OP_MUL:  result = operand_a * operand_b;
            OP_AND:  result = operand_a & operand_b;
            OP_OR:   result = operand_a | operand_b;
            OP_XOR:  result = operand_a ^ operand_b;
            OP_SHL:  result = operand_a << shamt;
            OP_SHR:  result = operand_a >> shamt;
            OP_PASS: result = operand_a;
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/pe_result_reg.sv */
// PE result stage
// Result register, self-feedback value and masked direction valids

`default_nettype none
`timescale 1ns/1ns

`include "cgra_config.svh"

module pe_result_reg (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          fire,
    input  logic [`CGRA_DATA_WIDTH-1:0]   result,
    input  logic [3:0]                    out_mask,
    output logic [`CGRA_DATA_WIDTH-1:0]   data_out,
    output logic                          valid_out_n,
    output logic                          valid_out_e,
    output logic                          valid_out_s,
    output logic                          valid_out_w,
    output logic [`CGRA_DATA_WIDTH-1:0]   self_value
);

    logic [`CGRA_DATA_WIDTH-1:0] result_q;
    logic [3:0]                  valid_q;

    // Value holds between firings
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_q <= '0;
            valid_q  <= '0;
        end else begin
            valid_q <= fire ? out_mask : 4'b0000;
            if (fire) begin
                result_q <= result;
            end
        end
    end

    assign data_out    = result_q;
    assign self_value  = result_q;
    assign valid_out_n = valid_q[0];
    assign valid_out_e = valid_q[1];
    assign valid_out_s = valid_q[2];
    assign valid_out_w = valid_q[3];

endmodule

`default_nettype wire

/* rtl/cgra_pe.sv */
// One CGRA processing element
// Decode, execute and result stages with self-feedback loop

`default_nettype none
`timescale 1ns/1ns

`include "cgra_config.svh"

module cgra_pe import cgra_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [`CGRA_FRAME_WIDTH-1:0]  config_frame,
    input  logic                          config_valid,
    input  logic [`CGRA_DATA_WIDTH-1:0]   data_in_n,
    input  logic [`CGRA_DATA_WIDTH-1:0]   data_in_e,
    input  logic [`CGRA_DATA_WIDTH-1:0]   data_in_s,
    input  logic [`CGRA_DATA_WIDTH-1:0]   data_in_w,
    input  logic                          valid_in_n,
    input  logic                          valid_in_e,
    input  logic                          valid_in_s,
    input  logic                          valid_in_w,
    output logic [`CGRA_DATA_WIDTH-1:0]   data_out,
    output logic                          valid_out_n,
    output logic                          valid_out_e,
    output logic                          valid_out_s,
    output logic                          valid_out_w
);

    pe_opcode_e                  opcode;
    logic [`CGRA_DATA_WIDTH-1:0] operand_a;
    logic [`CGRA_DATA_WIDTH-1:0] operand_b;
    logic [`CGRA_DATA_WIDTH-1:0] result;
    logic [`CGRA_DATA_WIDTH-1:0] self_value;
    logic [3:0]                  out_mask;
    logic                        fire;

    pe_config_decode i_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .config_frame (config_frame),
        .config_valid (config_valid),
        .data_in_n    (data_in_n),
        .data_in_e    (data_in_e),
        .data_in_s    (data_in_s),
        .data_in_w    (data_in_w),
        .valid_in_n   (valid_in_n),
        .valid_in_e   (valid_in_e),
        .valid_in_s   (valid_in_s),
        .valid_in_w   (valid_in_w),
        .self_value   (self_value),
        .opcode       (opcode),
        .operand_a    (operand_a),
        .operand_b    (operand_b),
        .out_mask     (out_mask),
        .fire         (fire)
    );

    pe_alu i_alu (
        .opcode    (opcode),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .result    (result)
    );

    // Last result feeds back to decode for accumulation
    pe_result_reg i_result (
        .clk         (clk),
        .rst_n       (rst_n),
        .fire        (fire),
        .result      (result),
        .out_mask    (out_mask),
        .data_out    (data_out),
        .valid_out_n (valid_out_n),
        .valid_out_e (valid_out_e),
        .valid_out_s (valid_out_s),
        .valid_out_w (valid_out_w),
        .self_value  (self_value)
    );

endmodule

`default_nettype wire

/* rtl/cgra_array.sv */
// CGRA mesh top level
// Generate-built grid of PEs, neighbor links and edge port wiring

`default_nettype none
`timescale 1ns/1ns

`include "cgra_config.svh"

module cgra_array (
    input  logic                                                  clk,
    input  logic                                                  rst_n,
    // Frame index is row * COLS + column
    input  logic [`CGRA_ROWS*`CGRA_COLS-1:0][`CGRA_FRAME_WIDTH-1:0] config_frames,
    input  logic                                                  config_valid,
    // North and south indexed by column, east and west by row
    input  logic [`CGRA_COLS-1:0][`CGRA_DATA_WIDTH-1:0]  edge_data_in_n,
    input  logic [`CGRA_COLS-1:0]                        edge_valid_in_n,
    input  logic [`CGRA_COLS-1:0][`CGRA_DATA_WIDTH-1:0]  edge_data_in_s,
    input  logic [`CGRA_COLS-1:0]                        edge_valid_in_s,
    input  logic [`CGRA_ROWS-1:0][`CGRA_DATA_WIDTH-1:0]  edge_data_in_e,
    input  logic [`CGRA_ROWS-1:0]                        edge_valid_in_e,
    input  logic [`CGRA_ROWS-1:0][`CGRA_DATA_WIDTH-1:0]  edge_data_in_w,
    input  logic [`CGRA_ROWS-1:0]                        edge_valid_in_w,
    output logic [`CGRA_COLS-1:0][`CGRA_DATA_WIDTH-1:0]  edge_data_out_n,
    output logic [`CGRA_COLS-1:0]                        edge_valid_out_n,
    output logic [`CGRA_COLS-1:0][`CGRA_DATA_WIDTH-1:0]  edge_data_out_s,
    output logic [`CGRA_COLS-1:0]                        edge_valid_out_s,
    output logic [`CGRA_ROWS-1:0][`CGRA_DATA_WIDTH-1:0]  edge_data_out_e,
    output logic [`CGRA_ROWS-1:0]                        edge_valid_out_e,
    output logic [`CGRA_ROWS-1:0][`CGRA_DATA_WIDTH-1:0]  edge_data_out_w,
    output logic [`CGRA_ROWS-1:0]                        edge_valid_out_w
);

    // One data value per PE, shared by all four directions
    logic [`CGRA_DATA_WIDTH-1:0] pe_data    [`CGRA_ROWS][`CGRA_COLS];
    logic                        pe_valid_n [`CGRA_ROWS][`CGRA_COLS];
    logic                        pe_valid_e [`CGRA_ROWS][`CGRA_COLS];
    logic                        pe_valid_s [`CGRA_ROWS][`CGRA_COLS];
    logic                        pe_valid_w [`CGRA_ROWS][`CGRA_COLS];

    genvar r, c;

    // ==================================================
    // PE grid
    // ==================================================
    for (r = 0; r < `CGRA_ROWS; r++) begin : g_row
        for (c = 0; c < `CGRA_COLS; c++) begin : g_col
            logic [`CGRA_DATA_WIDTH-1:0] in_n, in_e, in_s, in_w;
            logic                        vin_n, vin_e, vin_s, vin_w;

            if (r == 0) begin : g_n_edge
                assign in_n  = edge_data_in_n[c];
                assign vin_n = edge_valid_in_n[c];
            end else begin : g_n_link
                assign in_n  = pe_data[r-1][c];
                assign vin_n = pe_valid_s[r-1][c];
            end

            if (c == `CGRA_COLS-1) begin : g_e_edge
                assign in_e  = edge_data_in_e[r];
                assign vin_e = edge_valid_in_e[r];
            end else begin : g_e_link
                assign in_e  = pe_data[r][c+1];
                assign vin_e = pe_valid_w[r][c+1];
            end

            if (r == `CGRA_ROWS-1) begin : g_s_edge
                assign in_s  = edge_data_in_s[c];
                assign vin_s = edge_valid_in_s[c];
            end else begin : g_s_link
                assign in_s  = pe_data[r+1][c];
                assign vin_s = pe_valid_n[r+1][c];
            end

            if (c == 0) begin : g_w_edge
                assign in_w  = edge_data_in_w[r];
                assign vin_w = edge_valid_in_w[r];
            end else begin : g_w_link
                assign in_w  = pe_data[r][c-1];
                assign vin_w = pe_valid_e[r][c-1];
            end

            cgra_pe i_pe (
                .clk          (clk),
                .rst_n        (rst_n),
                .config_frame (config_frames[r*`CGRA_COLS+c]),
                .config_valid (config_valid),
                .data_in_n    (in_n),
                .data_in_e    (in_e),
                .data_in_s    (in_s),
                .data_in_w    (in_w),
                .valid_in_n   (vin_n),
                .valid_in_e   (vin_e),
                .valid_in_s   (vin_s),
                .valid_in_w   (vin_w),
                .data_out     (pe_data[r][c]),
                .valid_out_n  (pe_valid_n[r][c]),
                .valid_out_e  (pe_valid_e[r][c]),
                .valid_out_s  (pe_valid_s[r][c]),
                .valid_out_w  (pe_valid_w[r][c])
            );
        end
    end

    // ==================================================
    // Edge outputs from border PEs
    // ==================================================
    for (c = 0; c < `CGRA_COLS; c++) begin : g_edge_ns
        assign edge_data_out_n[c]  = pe_data[0][c];
        assign edge_valid_out_n[c] = pe_valid_n[0][c];
        assign edge_data_out_s[c]  = pe_data[`CGRA_ROWS-1][c];
        assign edge_valid_out_s[c] = pe_valid_s[`CGRA_ROWS-1][c];
    end

    for (r = 0; r < `CGRA_ROWS; r++) begin : g_edge_ew
        assign edge_data_out_e[r]  = pe_data[r][`CGRA_COLS-1];
        assign edge_valid_out_e[r] = pe_valid_e[r][`CGRA_COLS-1];
        assign edge_data_out_w[r]  = pe_data[r][0];
        assign edge_valid_out_w[r] = pe_valid_w[r][0];
    end

endmodule

`default_nettype wire

/* dv/cgra_ref_model.svh */
// Cycle-level reference model of the CGRA mesh
// Per-PE frame, output data, direction valids and self value, plus step task

`ifndef CGRA_REF_MODEL_SVH
`define CGRA_REF_MODEL_SVH

localparam int NUM_PE = `CGRA_ROWS * `CGRA_COLS;

logic [`CGRA_FRAME_WIDTH-1:0] m_frame [NUM_PE];
logic [`CGRA_DATA_WIDTH-1:0]  m_data  [NUM_PE];
logic [3:0]                   m_valid [NUM_PE];
logic [`CGRA_DATA_WIDTH-1:0]  m_self  [NUM_PE];

// Opcode table, codes above 9 never fire so they never get here
function automatic logic [15:0] ref_alu(input logic [3:0] op, input logic [15:0] a,
                                        input logic [15:0] b);
    case (op)
        OP_ADD:  ref_alu = a + b;
        OP_SUB:  ref_alu = a - b;
        OP_MUL:  ref_alu = a * b;
        OP_AND:  ref_alu = a & b;
        OP_OR:   ref_alu = a | b;
        OP_XOR:  ref_alu = a ^ b;
        OP_SHL:  ref_alu = a << b[3:0];
        OP_SHR:  ref_alu = a >> b[3:0];
        default: ref_alu = a;
    endcase
endfunction

// One clock edge of the whole mesh, from values seen just before the edge
task automatic model_step();
    logic [15:0] nd [NUM_PE];
    logic [3:0]  nv [NUM_PE];
    logic [15:0] din [4];
    logic        vin [4];
    logic [15:0] a;
    logic [15:0] b;
    logic        a_ok;
    logic        b_ok;
    logic        fire;
    logic [2:0]  sa;
    logic [2:0]  sb;
    logic [3:0]  op;
    logic [63:0] f;
    int          p;
    for (int r = 0; r < `CGRA_ROWS; r++) begin
        for (int c = 0; c < `CGRA_COLS; c++) begin
            p = r * `CGRA_COLS + c;
            f = m_frame[p];
            // Neighbor order N, E, S, W matches the source codes
            din[0] = (r == 0) ? edge_data_in_n[c] : m_data[p-`CGRA_COLS];
            vin[0] = (r == 0) ? edge_valid_in_n[c] : m_valid[p-`CGRA_COLS][2];
            din[1] = (c == `CGRA_COLS-1) ? edge_data_in_e[r] : m_data[p+1];
            vin[1] = (c == `CGRA_COLS-1) ? edge_valid_in_e[r] : m_valid[p+1][3];
            din[2] = (r == `CGRA_ROWS-1) ? edge_data_in_s[c] : m_data[p+`CGRA_COLS];
            vin[2] = (r == `CGRA_ROWS-1) ? edge_valid_in_s[c] : m_valid[p+`CGRA_COLS][0];
            din[3] = (c == 0) ? edge_data_in_w[r] : m_data[p-1];
            vin[3] = (c == 0) ? edge_valid_in_w[r] : m_valid[p-1][1];
            op = f[`CGRA_OP_LSB +: 4];
            sa = f[`CGRA_SRC_A_LSB +: 3];
            sb = f[`CGRA_SRC_B_LSB +: 3];
            a = (sa < 4) ? din[sa[1:0]] : (sa == 4) ? m_self[p] : f[`CGRA_IMM_LSB +: 16];
            b = (sb < 4) ? din[sb[1:0]] : (sb == 4) ? m_self[p] : f[`CGRA_IMM_LSB +: 16];
            a_ok = (sa < 4) ? vin[sa[1:0]] : 1'b1;
            b_ok = (sb < 4) ? vin[sb[1:0]] : 1'b1;
            fire = !config_valid && op >= 1 && op <= 9 && a_ok && b_ok;
            nv[p] = fire ? f[`CGRA_MASK_LSB +: 4] : 4'b0000;
            nd[p] = fire ? ref_alu(op, a, b) : m_data[p];
        end
    end
    for (int i = 0; i < NUM_PE; i++) begin
        if (!rst_n) begin
            m_frame[i] = '0;
            m_data[i]  = '0;
            m_valid[i] = '0;
            m_self[i]  = '0;
        end else begin
            m_data[i]  = nd[i];
            m_valid[i] = nv[i];
            m_self[i]  = nd[i];
            if (config_valid) begin
                m_frame[i] = config_frames[i];
            end
        end
    end
endtask

`endif

/* dv/cgra_tb.sv */
// CGRA mesh testbench
// LFSR stimulus over six phases, model comparison at every edge
// Cycle-count timeout and closing error report

`default_nettype none
`timescale 1ns/1ns

`include "cgra_config.svh"

module cgra_tb import cgra_pkg::*; ();

    typedef logic [`CGRA_ROWS*`CGRA_COLS-1:0][`CGRA_FRAME_WIDTH-1:0] frame_set_t;

    // Reset, six phases and a short drain at the end
    localparam int PHASE_CYCLES   = 10 + 20 + 41 + 300 + 61 + 61 + 401 + 5;
    localparam int TIMEOUT_CYCLES = PHASE_CYCLES + 200;

    logic clk;
    logic rst_n;
    frame_set_t config_frames;
    logic config_valid;
    logic [`CGRA_COLS-1:0][`CGRA_DATA_WIDTH-1:0] edge_data_in_n, edge_data_in_s;
    logic [`CGRA_ROWS-1:0][`CGRA_DATA_WIDTH-1:0] edge_data_in_e, edge_data_in_w;
    logic [`CGRA_COLS-1:0] edge_valid_in_n, edge_valid_in_s;
    logic [`CGRA_ROWS-1:0] edge_valid_in_e, edge_valid_in_w;
    logic [`CGRA_COLS-1:0][`CGRA_DATA_WIDTH-1:0] edge_data_out_n, edge_data_out_s;
    logic [`CGRA_ROWS-1:0][`CGRA_DATA_WIDTH-1:0] edge_data_out_e, edge_data_out_w;
    logic [`CGRA_COLS-1:0] edge_valid_out_n, edge_valid_out_s;
    logic [`CGRA_ROWS-1:0] edge_valid_out_e, edge_valid_out_w;

    logic [31:0] lfsr_state = 32'd98236;
    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;
    logic        timed_out = 1'b0;
    logic        check_en = 1'b0;

    `include "cgra_ref_model.svh"

    cgra_array i_cgra_array (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v = {v[30:0], fb};
        end
        rand_bits = v;
    endfunction

    function automatic logic [63:0] make_frame(input logic [3:0] op, input logic [2:0] src_a,
            input logic [2:0] src_b, input logic [3:0] mask, input logic [15:0] imm);
        logic [63:0] f;
        f = '0;
        f[`CGRA_OP_LSB +: 4] = op;
        f[`CGRA_SRC_A_LSB +: 3] = src_a;
        f[`CGRA_SRC_B_LSB +: 3] = src_b;
        f[`CGRA_MASK_LSB +: 4] = mask;
        f[`CGRA_IMM_LSB +: 16] = imm;
        make_frame = f;
    endfunction

    task automatic drive_random_edges(input logic west_always);
        for (int i = 0; i < 4; i++) begin
            edge_data_in_n[i]  <= 16'(rand_bits(16));
            edge_data_in_e[i]  <= 16'(rand_bits(16));
            edge_data_in_s[i]  <= 16'(rand_bits(16));
            edge_data_in_w[i]  <= 16'(rand_bits(16));
            edge_valid_in_n[i] <= 1'(rand_bits(1));
            edge_valid_in_e[i] <= 1'(rand_bits(1));
            edge_valid_in_s[i] <= 1'(rand_bits(1));
            edge_valid_in_w[i] <= west_always ? 1'b1 : 1'(rand_bits(1));
        end
    endtask

    task automatic run_cycles(input int n, input logic west_always);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            config_valid <= 1'b0;
            drive_random_edges(west_always);
        end
    endtask

    task automatic load_frames(input frame_set_t frames, input logic west_always);
        @(posedge clk);
        config_frames <= frames;
        config_valid  <= 1'b1;
        drive_random_edges(west_always);
    endtask

    task automatic check_port(input string side, input int idx, input logic exp_v,
            input logic act_v, input logic [15:0] exp_d, input logic [15:0] act_d);
        check_count++;
        assert (act_v === exp_v) else begin
            error_count++;
            $display("Error at %0t: edge_valid_out_%s[%0d] expected %0b actual %0b",
                     $time, side, idx, exp_v, act_v);
        end
        if (exp_v) begin
            assert (act_d === exp_d) else begin
                error_count++;
                $display("Error at %0t: edge_data_out_%s[%0d] expected %h actual %h",
                         $time, side, idx, exp_d, act_d);
            end
        end
    endtask

    task automatic compare_outputs();
        int s;
        for (int i = 0; i < 4; i++) begin
            s = (`CGRA_ROWS - 1) * `CGRA_COLS + i;
            check_port("n", i, m_valid[i][0], edge_valid_out_n[i], m_data[i], edge_data_out_n[i]);
            check_port("s", i, m_valid[s][2], edge_valid_out_s[i], m_data[s], edge_data_out_s[i]);
            s = i * `CGRA_COLS + `CGRA_COLS - 1;
            check_port("e", i, m_valid[s][1], edge_valid_out_e[i], m_data[s], edge_data_out_e[i]);
            s = i * `CGRA_COLS;
            check_port("w", i, m_valid[s][3], edge_valid_out_w[i], m_data[s], edge_data_out_w[i]);
        end
    endtask

    task automatic finish_run();
        $display("Checks %0d, errors %0d, timeouts %0d", check_count, error_count, timed_out);
        if (error_count == 0 && !timed_out) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    always @(posedge clk) begin
        model_step();
    end

    // Outputs are settled at the falling edge
    always @(negedge clk) begin
        if (check_en) begin
            compare_outputs();
        end
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        timed_out = 1'b1;
        $display("Timeout: stimulus still running after %0d cycles", cycle_count);
        finish_run();
    end

    initial begin
        frame_set_t pass_east;
        frame_set_t fs;
        rst_n = 1'b0;
        config_valid = 1'b0;
        config_frames = '0;
        edge_data_in_n = '0;
        edge_data_in_e = '0;
        edge_data_in_s = '0;
        edge_data_in_w = '0;
        edge_valid_in_n = '0;
        edge_valid_in_e = '0;
        edge_valid_in_s = '0;
        edge_valid_in_w = '0;
        for (int i = 0; i < NUM_PE; i++) begin
            pass_east[i] = make_frame(OP_PASS, SRC_W, SRC_W, 4'b0010, 16'h0);
        end
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        check_en = 1'b1;

        // ==================================================
        // Idle after reset, then row pass-through
        // ==================================================
        run_cycles(20, 1'b0);
        load_frames(pass_east, 1'b1);
        run_cycles(40, 1'b1);

        // ==================================================
        // ALU coverage in column 0, reloaded every 30 cycles
        // ==================================================
        for (int k = 0; k < 10; k++) begin
            fs = pass_east;
            for (int r = 0; r < `CGRA_ROWS; r++) begin
                fs[r*`CGRA_COLS] = make_frame(4'(rand_bits(4) % 9 + 1), SRC_W, SRC_IMM,
                                              4'b0010, 16'(rand_bits(16)));
            end
            load_frames(fs, 1'b1);
            run_cycles(29, 1'b1);
        end

        // Firing gate with random west valids
        load_frames(pass_east, 1'b0);
        run_cycles(60, 1'b0);

        // Accumulator at the bottom of column 0, passing north
        fs = '0;
        fs[(`CGRA_ROWS-1)*`CGRA_COLS] = make_frame(OP_ADD, SRC_SELF, SRC_W, 4'b0001, 16'h0);
        for (int r = 0; r < `CGRA_ROWS - 1; r++) begin
            fs[r*`CGRA_COLS] = make_frame(OP_PASS, SRC_S, SRC_S, 4'b0001, 16'h0);
        end
        load_frames(fs, 1'b0);
        run_cycles(60, 1'b0);

        // ==================================================
        // Fully random frames and inputs
        // ==================================================
        for (int i = 0; i < NUM_PE; i++) begin
            fs[i] = {rand_bits(32), rand_bits(32)};
        end
        load_frames(fs, 1'b0);
        for (int k = 0; k < 400; k++) begin
            if (3'(rand_bits(3)) == 3'd0) begin
                for (int i = 0; i < NUM_PE; i++) begin
                    fs[i] = {rand_bits(32), rand_bits(32)};
                end
                load_frames(fs, 1'b0);
            end else begin
                run_cycles(1, 1'b0);
            end
        end
        run_cycles(5, 1'b0);
        finish_run();
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+rtl
+incdir+dv
rtl/cgra_pkg.sv
rtl/pe_config_decode.sv
rtl/pe_alu.sv
rtl/pe_result_reg.sv
rtl/cgra_pe.sv
rtl/cgra_array.sv
dv/cgra_tb.sv

/* Makefile */
# Verilator build, run and lint for the CGRA mesh

VERILATOR ?= verilator
TOP       ?= cgra_tb
RTL_TOP   ?= cgra_array
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

.PHONY: all run build lint clean

all: run

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Testbench passed$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
